/* src/exec_pkg.sv */
package exec_pkg;

    typedef logic [4:0]  reg_addr_t;                  // Register number
    typedef logic [31:0] word_t;                      // Data word

    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_sub  = 4'd1,
        op_and  = 4'd2,
        op_or   = 4'd3,
        op_xor  = 4'd4,
        op_sll  = 4'd5,
        op_srl  = 4'd6,
        op_sra  = 4'd7,
        op_slt  = 4'd8,
        op_sltu = 4'd9,
        op_beq  = 4'd10,
        op_bne  = 4'd11,
        op_blt  = 4'd12,
        op_bge  = 4'd13,
        op_bltu = 4'd14,
        op_bgeu = 4'd15
    } alu_op_t;

    // Write source of the register file
    typedef enum logic [1:0] {
        wb_none   = 2'b00,                            // No write
        wb_memory = 2'b01,
        wb_fetch  = 2'b10,
        wb_alu    = 2'b11
    } wb_sel_t;

    typedef struct packed {
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        alu_op_t   op;
        logic      use_imm;                           // Second operand from imm
        word_t     imm;
        logic      wb_en;                             // Instruction writes rd
    } decode_t;

    typedef struct packed {
        logic    valid;
        decode_t instr;
        word_t   rs1_val;
        word_t   rs2_val;
    } operand_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        logic      wb_en;
        word_t     value;
        logic      branch_taken;
    } exec_result_t;

    function automatic logic is_branch_op(alu_op_t op);
        return op inside {op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu};
    endfunction

    // Ops whose result comes from the compare unit
    function automatic logic is_compare_op(alu_op_t op);
        return (op == op_slt) || (op == op_sltu) || is_branch_op(op);
    endfunction

endpackage

/* src/register_file.sv */
`timescale 1ns/1ps

module register_file (
    input  logic                  clk,
    input  logic                  nRst,
    input  logic                  instr_valid,        // Issue strobe
    input  exec_pkg::decode_t     instr,
    input  exec_pkg::exec_result_t wb,                // Writeback from the merge stage
    input  logic                  ext_write,
    input  exec_pkg::wb_sel_t     ext_src,            // Memory or fetch
    input  exec_pkg::reg_addr_t   ext_rd,
    input  exec_pkg::word_t       ext_data,
    output exec_pkg::operand_t    opnd
);

    import exec_pkg::*;

    wb_sel_t   wr_src;                                // Selected write source
    reg_addr_t wr_rd;
    word_t     wr_data;

    word_t [31:0] regs;                               // Register array

    operand_t opnd_n;

    // Writeback from execute wins over the external port
    always_comb begin : pick_source
        if (wb.valid && wb.wb_en) begin
            wr_src = wb_alu;
            wr_rd  = wb.rd;
        end else if (ext_write) begin
            wr_src = ext_src;
            wr_rd  = ext_rd;
        end else begin
            wr_src = wb_none;
            wr_rd  = ext_rd;
        end
    end

    always_comb begin : select_data
        case (wr_src)
            wb_memory, wb_fetch: wr_data = ext_data;  // Load data or return address
            wb_alu:              wr_data = wb.value;
            default:             wr_data = '0;
        endcase
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            regs <= '0;
        end else if (wr_src != wb_none) begin
            regs[wr_rd] <= wr_data;
        end
    end

    // Operand stage latches the instruction with both reads.
    // On an idle cycle the contents are held and only valid drops.
    always_comb begin : operand_next
        opnd_n       = opnd;
        opnd_n.valid = 1'b0;
        if (instr_valid) begin
            opnd_n.valid   = 1'b1;
            opnd_n.instr   = instr;
            opnd_n.rs1_val = regs[instr.rs1];         // Old value on a same-edge write
            opnd_n.rs2_val = regs[instr.rs2];
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            opnd <= '0;
        end else begin
            opnd <= opnd_n;
        end
    end

endmodule

/* src/alu.sv */
`timescale 1ns/1ps

module alu (
    input  exec_pkg::operand_t opnd,
    output exec_pkg::word_t    alu_value
);

    import exec_pkg::*;

    word_t      op_a;
    word_t      op_b;                                 // rs2 or immediate
    logic [4:0] shamt;

    assign op_a  = opnd.rs1_val;
    assign op_b  = opnd.instr.use_imm ? opnd.instr.imm : opnd.rs2_val;
    assign shamt = op_b[4:0];                         // Low five bits only

    always_comb begin : compute
        case (opnd.instr.op)
            op_add: begin
                alu_value = op_a + op_b;
            end
            op_sub: begin
                alu_value = op_a - op_b;
            end
            op_and: begin
                alu_value = op_a & op_b;
            end
            op_or: begin
                alu_value = op_a | op_b;
            end
            op_xor: begin
                alu_value = op_a ^ op_b;
            end
            op_sll: begin
                alu_value = op_a << shamt;
            end
            op_srl: begin
                alu_value = op_a >> shamt;
            end
            op_sra: begin
                alu_value = $signed(op_a) >>> shamt;  // Sign fill
            end
            default: begin
                // Merge stage takes the compare unit result for these ops
                alu_value = op_a + op_b;
            end
        endcase
    end

endmodule

/* src/compare_unit.sv */
`timescale 1ns/1ps

module compare_unit (
    input  exec_pkg::operand_t opnd,
    output exec_pkg::word_t    cmp_value,             // Set-less-than result as 0 or 1
    output logic               cmp_true               // Branch condition
);

    import exec_pkg::*;

    word_t op_a;
    word_t op_b;
    logic  eq;
    logic  lt_s;
    logic  lt_u;

    // Branches always look at rs2 while slt and sltu may use the immediate
    assign op_a = opnd.rs1_val;
    assign op_b = (is_branch_op(opnd.instr.op) || !opnd.instr.use_imm) ?
                  opnd.rs2_val : opnd.instr.imm;

    assign eq   = (op_a == op_b);
    assign lt_s = ($signed(op_a) < $signed(op_b));
    assign lt_u = (op_a < op_b);

    always_comb begin : evaluate
        cmp_value = '0;
        cmp_true  = 1'b0;
        case (opnd.instr.op)
            op_slt:  cmp_value[0] = lt_s;
            op_sltu: cmp_value[0] = lt_u;
            op_beq:  cmp_true = eq;
            op_bne:  cmp_true = !eq;
            op_blt:  cmp_true = lt_s;
            op_bge:  cmp_true = !lt_s;
            op_bltu: cmp_true = lt_u;
            op_bgeu: cmp_true = !lt_u;
            default: begin
                cmp_value = '0;
                cmp_true  = 1'b0;
            end
        endcase
    end

endmodule

/* src/exec_merge.sv */
`timescale 1ns/1ps

module exec_merge (
    input  logic                   clk,
    input  logic                   nRst,
    input  exec_pkg::operand_t     opnd,
    input  exec_pkg::word_t        alu_value,
    input  exec_pkg::word_t        cmp_value,
    input  logic                   cmp_true,
    output exec_pkg::exec_result_t result
);

    import exec_pkg::*;

    exec_result_t result_n;
    logic         branch;
    logic         compare;

    assign branch  = is_branch_op(opnd.instr.op);
    assign compare = is_compare_op(opnd.instr.op);

    always_comb begin : merge
        result_n       = result;                      // Payload held when idle
        result_n.valid = 1'b0;
        if (opnd.valid) begin
            result_n.valid        = 1'b1;
            result_n.rd           = opnd.instr.rd;
            result_n.wb_en        = opnd.instr.wb_en && !branch;  // Branches never write
            result_n.value        = compare ? cmp_value : alu_value;
            result_n.branch_taken = branch && cmp_true;
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            result <= '0;
        end else begin
            result <= result_n;
        end
    end

endmodule

/* src/exec_top.sv */
`timescale 1ns/1ps

module exec_top (
    input  logic                   clk,
    input  logic                   nRst,
    input  logic                   issue,             // One-cycle issue strobe
    input  exec_pkg::decode_t      instr,
    input  logic                   ext_write,         // Load or fetch write strobe
    input  exec_pkg::wb_sel_t      ext_src,
    input  exec_pkg::reg_addr_t    ext_rd,
    input  exec_pkg::word_t        ext_data,
    output exec_pkg::exec_result_t result
);

    import exec_pkg::*;

    operand_t opnd;
    word_t    alu_value;
    word_t    cmp_value;
    logic     cmp_true;

    register_file rf_i (
        .clk         (clk),
        .nRst        (nRst),
        .instr_valid (issue),
        .instr       (instr),
        .wb          (result),                        // Writeback loop
        .ext_write   (ext_write),
        .ext_src     (ext_src),
        .ext_rd      (ext_rd),
        .ext_data    (ext_data),
        .opnd        (opnd)
    );

    alu alu_i (
        .opnd      (opnd),
        .alu_value (alu_value)
    );

    compare_unit cmp_i (
        .opnd      (opnd),
        .cmp_value (cmp_value),
        .cmp_true  (cmp_true)
    );

    exec_merge merge_i (
        .clk       (clk),
        .nRst      (nRst),
        .opnd      (opnd),
        .alu_value (alu_value),
        .cmp_value (cmp_value),
        .cmp_true  (cmp_true),
        .result    (result)
    );

endmodule

/* tb/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic nRst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                        // 10 ns period
    end

    initial begin
        nRst = 1'b0;
        repeat (4) @(posedge clk);                    // Four cycles in reset
        @(negedge clk);
        nRst = 1'b1;
    end

endmodule

/* tb/exec_asserts.sv */
`timescale 1ns/1ps

module exec_asserts (
    input logic                   clk,
    input logic                   nRst,
    input logic                   issue,
    input logic                   ext_write,
    input exec_pkg::exec_result_t result
);

    // Only one source may use the write port in a cycle
    write_port_collision: assert property (@(posedge clk) disable iff (!nRst)
        !(ext_write && result.valid && result.wb_en))
        else $error("External write collides with an execute writeback");

    issue_gives_result: assert property (@(posedge clk) disable iff (!nRst)
        issue |-> ##2 result.valid)
        else $error("Result did not follow issue after two cycles");

    no_result_without_issue: assert property (@(posedge clk) disable iff (!nRst)
        result.valid |-> $past(issue, 2))
        else $error("Result valid without a matching issue");

endmodule

bind exec_top exec_asserts asserts_i (
    .clk       (clk),
    .nRst      (nRst),
    .issue     (issue),
    .ext_write (ext_write),
    .result    (result)
);

/* tb/exec_tb.sv */
`timescale 1ns/1ps

module exec_tb;

    import exec_pkg::*;

    localparam int n_arith       = 40;                // Random ALU ops issued every third cycle
    localparam int n_edges       = 7;
    localparam int n_cmp_rand    = 24;
    localparam int n_b2b         = 100;
    localparam int t1_cycles     = 40;
    localparam int t2_cycles     = 70;
    localparam int t3_cycles     = n_arith * 3 + 36;
    localparam int t4_cycles     = (n_edges * 8 + n_cmp_rand) * 5 + 4;
    localparam int t5_cycles     = n_b2b + 8;
    localparam int stim_cycles   = t1_cycles + t2_cycles + t3_cycles + t4_cycles + t5_cycles;
    localparam int timeout_limit = 4 * stim_cycles + 100;

    logic         clk;
    logic         nRst;
    logic         issue;
    decode_t      instr;
    logic         ext_write;
    wb_sel_t      ext_src;
    reg_addr_t    ext_rd;
    word_t        ext_data;
    exec_result_t result;

    word_t        model_regs [32];                    // Reference register array
    int           due_q [$];                          // Edge after which a result is due
    exec_result_t exp_q [$];
    int           wr_due_q [$];                       // Pending writebacks
    reg_addr_t    wr_rd_q [$];
    word_t        wr_val_q [$];
    int           edge_n = 0;
    int           cycle_count = 0;
    int           err_count = 0;
    integer       seed;
    string        test_name;

    tb_clock clock_i (
        .clk  (clk),
        .nRst (nRst)
    );

    exec_top dut_i (
        .clk       (clk),
        .nRst      (nRst),
        .issue     (issue),
        .instr     (instr),
        .ext_write (ext_write),
        .ext_src   (ext_src),
        .ext_rd    (ext_rd),
        .ext_data  (ext_data),
        .result    (result)
    );

    function automatic exec_result_t ref_result(alu_op_t op, word_t a, word_t r2, word_t imm,
                                                logic use_imm, reg_addr_t rd, logic wb_en);
        exec_result_t r;
        word_t        b;
        logic [4:0]   sh;
        logic         branch;
        b      = use_imm ? imm : r2;
        sh     = b[4:0];
        branch = (op >= op_beq);                      // Branches sit at the top of the encoding
        r.valid        = 1'b1;
        r.rd           = rd;
        r.wb_en        = wb_en && !branch;
        r.value        = '0;
        r.branch_taken = 1'b0;
        case (op)
            op_add:  r.value = a + b;
            op_sub:  r.value = a - b;
            op_and:  r.value = a & b;
            op_or:   r.value = a | b;
            op_xor:  r.value = a ^ b;
            op_sll:  r.value = a << sh;
            op_srl:  r.value = a >> sh;
            op_sra:  r.value = (a >> sh) | ({32{a[31]}} & ~(32'hffff_ffff >> sh));
            op_slt:  r.value = {31'd0, ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000))};
            op_sltu: r.value = {31'd0, (a < b)};
            // Branches compare against rs2 whatever use_imm says
            op_beq:  r.branch_taken = (a == r2);
            op_bne:  r.branch_taken = (a != r2);
            op_blt:  r.branch_taken = ((a ^ 32'h8000_0000) < (r2 ^ 32'h8000_0000));
            op_bge:  r.branch_taken = ((a ^ 32'h8000_0000) >= (r2 ^ 32'h8000_0000));
            op_bltu: r.branch_taken = (a < r2);
            op_bgeu: r.branch_taken = (a >= r2);
            default: r.value = '0;
        endcase
        return r;
    endfunction

    function automatic logic [63:0] edge_pair(int k);
        case (k)
            0:       return {32'h0000_0000, 32'h0000_0000};
            1:       return {32'h8000_0000, 32'h7fff_ffff};   // Sign boundary
            2:       return {32'h7fff_ffff, 32'h8000_0000};
            3:       return {32'hffff_ffff, 32'h0000_0001};
            4:       return {32'h0000_0001, 32'hffff_ffff};
            5:       return {32'h8000_0000, 32'h8000_0000};
            default: return {32'h1234_5678, 32'h1234_5678};
        endcase
    endfunction

    function automatic word_t rand_word();
        return $random(seed);
    endfunction

    function automatic reg_addr_t rand_reg();
        logic [31:0] r;
        r = $random(seed);
        return r[4:0];
    endfunction

    function automatic reg_addr_t low_reg();
        logic [31:0] r;
        r = $random(seed);
        return {2'b00, r[2:0]};                       // Small set gives dependencies
    endfunction

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            err_count++;
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
            $display("sim failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic drive_idle();
        @(negedge clk);
        issue     = 1'b0;
        ext_write = 1'b0;
    endtask

    task automatic drain(int n);
        repeat (n) drive_idle();
    endtask

    task automatic drive_issue(reg_addr_t rs1, reg_addr_t rs2, reg_addr_t rd, alu_op_t op,
                               logic use_imm, word_t imm, logic wb_en);
        @(negedge clk);
        ext_write     = 1'b0;
        issue         = 1'b1;
        instr.rs1     = rs1;
        instr.rs2     = rs2;
        instr.rd      = rd;
        instr.op      = op;
        instr.use_imm = use_imm;
        instr.imm     = imm;
        instr.wb_en   = wb_en;
    endtask

    task automatic drive_ext(wb_sel_t src, reg_addr_t rd, word_t data);
        @(negedge clk);
        issue     = 1'b0;
        ext_write = 1'b1;
        ext_src   = src;
        ext_rd    = rd;
        ext_data  = data;
    endtask

    task automatic read_all_regs();
        for (int i = 0; i < 32; i++) begin
            drive_issue(reg_addr_t'(i), 5'd0, 5'd0, op_or, 1'b1, '0, 1'b0);
        end
    endtask

    // Load both operands, issue, then leave room for the writeback
    task automatic run_compare(alu_op_t op, word_t a, word_t b);
        logic [31:0] r;
        logic        use_imm;
        word_t       r2;
        word_t       imm;
        r       = $random(seed);
        use_imm = r[0];
        if (use_imm && op < op_beq) begin
            r2  = rand_word();
            imm = b;
        end else begin
            r2  = b;
            imm = rand_word();
        end
        drive_ext(wb_memory, 5'd1, a);
        drive_ext(wb_fetch, 5'd2, r2);
        drive_issue(5'd1, 5'd2, rand_reg(), op, use_imm, imm, 1'b1);
        drain(2);
    endtask

    // Reads at an edge see the array before any write of that edge
    always @(posedge clk) begin : model
        exec_result_t exp;
        if (nRst) begin
            edge_n = edge_n + 1;
            if (issue) begin
                exp = ref_result(instr.op, model_regs[instr.rs1], model_regs[instr.rs2],
                                 instr.imm, instr.use_imm, instr.rd, instr.wb_en);
                due_q.push_back(edge_n + 1);
                exp_q.push_back(exp);
                if (exp.wb_en) begin
                    wr_due_q.push_back(edge_n + 2);
                    wr_rd_q.push_back(exp.rd);
                    wr_val_q.push_back(exp.value);
                end
            end
            while (wr_due_q.size() > 0 && wr_due_q[0] == edge_n) begin
                model_regs[wr_rd_q[0]] = wr_val_q[0];
                void'(wr_due_q.pop_front());
                void'(wr_rd_q.pop_front());
                void'(wr_val_q.pop_front());
            end
            if (ext_write) begin
                model_regs[ext_rd] = ext_data;
            end
        end
    end

    always @(negedge clk) begin : compare
        if (nRst && edge_n > 0) begin
            if (due_q.size() > 0 && due_q[0] == edge_n) begin
                check(test_name, {24'd0, exp_q[0]}, {24'd0, result});
                void'(due_q.pop_front());
                void'(exp_q.pop_front());
            end else begin
                check(test_name, 64'd0, {63'd0, result.valid});   // Idle cycle
            end
        end
    end

    always @(posedge clk) begin : watchdog
        cycle_count++;
        if (cycle_count >= timeout_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("sim failed");
            $fatal(1, "Timeout");
        end
    end

    initial begin : stimulus
        logic [31:0] r;
        logic [63:0] pair;
        word_t       a;
        word_t       b;
        seed      = 32'h3003ace1;
        issue     = 1'b0;
        instr     = '0;
        ext_write = 1'b0;
        ext_src   = wb_none;
        ext_rd    = '0;
        ext_data  = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        test_name = "reset";
        @(posedge nRst);
        drive_idle();
        check(test_name, 64'd0, {63'd0, result.valid});

        test_name = "zero_read";
        for (int i = 0; i < 32; i++) begin
            drive_issue(reg_addr_t'(i), 5'd0, 5'd0, op_add, 1'b0, '0, 1'b0);
        end
        drain(4);

        test_name = "ext_write";
        for (int i = 0; i < 32; i++) begin
            drive_ext((i % 2 == 0) ? wb_memory : wb_fetch, reg_addr_t'(i), rand_word());
        end
        drain(2);                                     // First read three cycles after last write
        read_all_regs();
        drain(4);

        test_name = "arith";
        for (int i = 0; i < n_arith; i++) begin
            r = $random(seed);
            drive_issue(rand_reg(), rand_reg(), rand_reg(), alu_op_t'({1'b0, r[2:0]}), r[3],
                        rand_word(), 1'b1);
            drain(2);
        end
        read_all_regs();
        drain(4);

        test_name = "compare_edge";
        for (int i = 0; i < n_edges * 8; i++) begin
            pair = edge_pair(i / 8);
            run_compare(alu_op_t'(4'(8 + i % 8)), pair[63:32], pair[31:0]);
        end
        test_name = "compare_random";
        for (int i = 0; i < n_cmp_rand; i++) begin
            r = $random(seed);
            a = rand_word();
            b = r[4] ? a : rand_word();
            run_compare(alu_op_t'({1'b1, r[2:0]}), a, b);
        end
        drain(4);

        test_name = "back_to_back";
        for (int i = 0; i < n_b2b; i++) begin
            r = $random(seed);
            drive_issue(low_reg(), low_reg(), low_reg(), alu_op_t'(r[3:0]), r[4], rand_word(),
                        r[7:5] != 3'd0);
        end
        drain(8);

        if (due_q.size() != 0) begin
            $display("Expected results never appeared on the result port");
            err_count++;
        end
        if (err_count == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("sim failed");
            $fatal(1, "Run ended with errors");
        end
    end

endmodule

/* sim.f */
src/exec_pkg.sv
src/register_file.sv
src/alu.sv
src/compare_unit.sv
src/exec_merge.sv
src/exec_top.sv
tb/tb_clock.sv
tb/exec_asserts.sv
tb/exec_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := exec_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir

.PHONY: sim clean

# The pipeline status is the status of grep, so a missing pass line fails the target
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^sim passed$$"

clean:
	rm -rf $(OBJ_DIR)
